/* src.f */
+incdir+common
common/cart_map_pkg.sv
rtl/cpu_bus_capture.sv
map_decode/map_decode.sv
rtl/cart_mem_port.sv
rtl/cart_map_top.sv
test/cart_map_properties.sv
test/cart_map_tb.sv

/* test/cart_map_tb.sv */
// cartridge map testbench with clock, reset, memory models, lfsr, directed tests, checks, timeout
`include "cart_map_config.svh"

module cart_map_tb;

	localparam logic [31:0] LFSR_SEED = 32'h47dd7fc5;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam int MAX_CYCLES = 2000;
	// {rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n, bsram_we_n}
	localparam logic [4:0] ST_IDLE = 5'b11111;
	localparam logic [4:0] ST_ROM_RD = 5'b00111;
	localparam logic [4:0] ST_SRAM_RD = 5'b11001;
	localparam logic [4:0] ST_SRAM_WR = 5'b11010;

	logic                     mclk;
	logic                     rst;
	logic                     sysclkf_ce;
	logic [`CART_ADDR_W-1:0]  cpu_addr;
	logic                     cpu_rd_n;
	logic                     cpu_wr_n;
	logic                     romsel_n;
	logic                     ramsel_n;
	logic [`CART_DATA_W-1:0]  cpu_di;
	cart_map_pkg::map_cfg_t   map_cfg;
	logic [`CART_ADDR_W-1:0]  rom_addr;
	logic [`CART_ROM_Q_W-1:0] rom_q;
	logic                     rom_ce_n;
	logic                     rom_oe_n;
	logic [`CART_BSRAM_W-1:0] bsram_addr;
	logic [`CART_DATA_W-1:0]  bsram_d;
	logic [`CART_DATA_W-1:0]  bsram_q;
	logic                     bsram_ce_n;
	logic                     bsram_oe_n;
	logic                     bsram_we_n;
	logic [`CART_DATA_W-1:0]  cpu_do;
	logic [4:0]               strobes;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          cycle_count;
	// models cover 4K rom bytes folded with the upper address, and 16K of save ram
	logic [7:0]  rom_mem [0:4095];
	logic [7:0]  bsram_mem [0:16383];

	cart_map_top u_dut (.*);

	assign strobes = {rom_ce_n, rom_oe_n, bsram_ce_n, bsram_oe_n, bsram_we_n};

	initial begin
		mclk = 1'b0;
		forever #5 mclk = ~mclk;
	end

	always @(posedge mclk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) @(posedge mclk);
		$display("timeout: run exceeded %0d clocks without finishing", MAX_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return r;
	endfunction

	// every rom byte depends on all 24 address bits
	function automatic logic [7:0] rom_byte(input logic [23:0] a);
		return rom_mem[a[11:0]] ^ a[19:12] ^ {4'h0, a[23:20]};
	endfunction

	assign rom_q = {rom_byte(rom_addr | 24'h1), rom_byte(rom_addr & ~24'h1)};
	assign bsram_q = bsram_mem[bsram_addr[13:0]];

	always @(posedge mclk) begin
		if (!bsram_ce_n && !bsram_we_n) begin
			bsram_mem[bsram_addr[13:0]] <= bsram_d;
		end
	end

	// expected physical addresses from the map decode rules
	function automatic logic [23:0] lorom_rom(input logic [23:0] a, input logic [23:0] mask);
		return ((((a >> 16) & 24'h7F) << 15) | (a & 24'h7FFF)) & mask;
	endfunction

	function automatic logic [23:0] hirom_rom(input logic [23:0] a, input logic [23:0] mask);
		return ((((a >> 16) & 24'h3F) << 16) | (a & 24'hFFFF)) & mask;
	endfunction

	function automatic logic [23:0] lorom_sram(input logic [23:0] a, input logic [19:0] mask);
		return ((((a >> 16) & 24'hF) << 15) | (a & 24'h7FFF)) & {4'h0, mask};
	endfunction

	function automatic logic [23:0] hirom_sram(input logic [23:0] a, input logic [19:0] mask);
		return ((((a >> 16) & 24'h1F) << 13) | (a & 24'h1FFF)) & {4'h0, mask};
	endfunction

	task automatic check_byte(input logic [`CART_DATA_W-1:0] got,
			input logic [`CART_DATA_W-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input logic [`CART_ADDR_W-1:0] got,
			input logic [`CART_ADDR_W-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %06h expected %06h", $time, what, got, exp);
		end
	endtask

	task automatic check_strobes(input logic [4:0] got, input logic [4:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %05b expected %05b", $time, what, got, exp);
		end
	endtask

	task automatic next_edge();
		@(posedge mclk);
		#1;
	endtask

	task automatic drive_idle();
		sysclkf_ce = 1'b0;
		cpu_rd_n = 1'b1;
		cpu_wr_n = 1'b1;
		romsel_n = 1'b1;
		ramsel_n = 1'b1;
	endtask

	task automatic drive_cycle(input logic [23:0] addr, input logic wr, input logic romsel,
			input logic [7:0] wdata);
		sysclkf_ce = 1'b1;
		cpu_addr = addr;
		cpu_rd_n = wr;
		cpu_wr_n = ~wr;
		romsel_n = ~romsel;
		cpu_di = wdata;
	endtask

	// one bus cycle; ports sampled after E+2, cpu_do after E+3
	task automatic run_access(input logic [23:0] addr, input logic wr, input logic romsel,
			input logic [7:0] wdata, output logic [4:0] st, output logic [23:0] port_addr,
			output logic [7:0] bd, output logic [7:0] dout);
		drive_cycle(addr, wr, romsel, wdata);
		next_edge();
		drive_idle();
		next_edge();
		next_edge();
		st = strobes;
		port_addr = (st[2] == 1'b0) ? {4'h0, bsram_addr} : rom_addr;
		bd = bsram_d;
		next_edge();
		dout = cpu_do;
	endtask

	task automatic rom_read(input logic [23:0] addr, input logic [23:0] exp_addr);
		logic [4:0]  st;
		logic [23:0] pa;
		logic [7:0]  bd;
		logic [7:0]  dout;
		run_access(addr, 1'b0, 1'b1, 8'h00, st, pa, bd, dout);
		check_strobes(st, ST_ROM_RD, "rom read strobes");
		check_addr(pa, exp_addr, "rom_addr");
		check_byte(dout, rom_byte(exp_addr), "rom read data");
	endtask

	task automatic sram_round_trip(input logic [23:0] addr, input logic romsel,
			input logic [23:0] exp_addr);
		logic [4:0]  st;
		logic [23:0] pa;
		logic [7:0]  bd;
		logic [7:0]  dout;
		logic [7:0]  wdata;
		wdata = take_bits(8);
		run_access(addr, 1'b1, romsel, wdata, st, pa, bd, dout);
		check_strobes(st, ST_SRAM_WR, "save ram write strobes");
		check_addr(pa, exp_addr, "bsram_addr on write");
		check_byte(bd, wdata, "bsram_d");
		run_access(addr, 1'b0, romsel, 8'h00, st, pa, bd, dout);
		check_strobes(st, ST_SRAM_RD, "save ram read strobes");
		check_addr(pa, exp_addr, "bsram_addr on read");
		check_byte(dout, wdata, "save ram read back");
	endtask

	task automatic set_cfg(input cart_map_pkg::map_mode_e mode, input logic [23:0] rmask,
			input logic [19:0] bmask);
		map_cfg.mode = mode;
		map_cfg.rom_mask = rmask;
		map_cfg.bsram_mask = bmask;
	endtask

	task automatic test_reset();
		check_strobes(strobes, ST_IDLE, "strobes after reset");
		check_byte(cpu_do, 8'h00, "cpu_do after reset");
	endtask

	task automatic test_lorom_reads();
		logic [23:0] addr;
		set_cfg(cart_map_pkg::MAP_LOROM, 24'h3FFFFF, 20'h03FFF);
		for (int i = 0; i < 8; i++) begin
			addr = {8'(take_bits(8)), 1'b1, 15'(take_bits(15))};
			rom_read(addr, lorom_rom(addr, 24'h3FFFFF));
		end
	endtask

	task automatic test_hirom_reads();
		logic [23:0] addr;
		set_cfg(cart_map_pkg::MAP_HIROM, 24'h0FFFFF, 20'h03FFF);
		for (int i = 0; i < 8; i++) begin
			addr = take_bits(24);
			rom_read(addr, hirom_rom(addr, 24'h0FFFFF));
		end
	endtask

	task automatic test_save_ram();
		logic [23:0] addr;
		logic [4:0]  st;
		logic [23:0] pa;
		logic [7:0]  bd;
		logic [7:0]  dout;
		set_cfg(cart_map_pkg::MAP_LOROM, 24'h3FFFFF, 20'h03FFF);
		for (int i = 0; i < 4; i++) begin
			addr = {8'h70 + 8'(take_bits(4) % 14), 1'b0, 15'(take_bits(15))};
			sram_round_trip(addr, 1'b1, lorom_sram(addr, 20'h03FFF));
		end
		set_cfg(cart_map_pkg::MAP_HIROM, 24'hFFFFFF, 20'h03FFF);
		for (int i = 0; i < 4; i++) begin
			addr = {1'(take_bits(1)), 2'b01, 5'(take_bits(5)), 3'b011, 13'(take_bits(13))};
			sram_round_trip(addr, 1'b0, hirom_sram(addr, 20'h03FFF));
		end
		// rom is read only
		set_cfg(cart_map_pkg::MAP_LOROM, 24'h3FFFFF, 20'h03FFF);
		run_access(24'h00_9234, 1'b1, 1'b1, 8'hA5, st, pa, bd, dout);
		check_strobes(st, ST_IDLE, "rom write strobes");
	endtask

	task automatic test_open_bus();
		logic [23:0] addr;
		logic [4:0]  st;
		logic [23:0] pa;
		logic [7:0]  bd;
		logic [7:0]  dout;
		set_cfg(cart_map_pkg::MAP_HIROM, 24'hFFFFFF, 20'h03FFF);
		addr = take_bits(24);
		rom_read(addr, hirom_rom(addr, 24'hFFFFFF));
		set_cfg(cart_map_pkg::MAP_HIROM, 24'hFFFFFF, 20'h00000);
		run_access(24'h20_6000, 1'b0, 1'b0, 8'h00, st, pa, bd, dout);
		check_strobes(st, ST_IDLE, "no save ram strobes");
		check_byte(dout, rom_byte(hirom_rom(addr, 24'hFFFFFF)), "open bus keeps last byte");
	endtask

	// read k captured at edge k with ports after edge k+2 and data after edge k+3
	task automatic test_back_to_back();
		logic [23:0] exp_addr [0:3];
		logic [23:0] addr;
		set_cfg(cart_map_pkg::MAP_LOROM, 24'h3FFFFF, 20'h03FFF);
		for (int k = 0; k < 7; k++) begin
			if (k < 4) begin
				addr = {8'(take_bits(8)), 1'b1, 15'(take_bits(15))};
				exp_addr[k] = lorom_rom(addr, 24'h3FFFFF);
				drive_cycle(addr, 1'b0, 1'b1, 8'h00);
			end else begin
				drive_idle();
			end
			next_edge();
			if (k >= 2 && k < 6) begin
				check_strobes(strobes, ST_ROM_RD, "back to back strobes");
				check_addr(rom_addr, exp_addr[k-2], "back to back rom_addr");
			end
			if (k >= 3) begin
				check_byte(cpu_do, rom_byte(exp_addr[k-3]), "back to back read data");
			end
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		lfsr = LFSR_SEED;
		rst = 1'b1;
		cpu_addr = '0;
		cpu_di = '0;
		drive_idle();
		set_cfg(cart_map_pkg::MAP_LOROM, 24'h3FFFFF, 20'h03FFF);
		for (int i = 0; i < 4096; i++) begin
			rom_mem[i] = take_bits(8);
		end
		for (int i = 0; i < 16384; i++) begin
			bsram_mem[i] = take_bits(8);
		end
		repeat (10) @(posedge mclk);
		#1;
		rst = 1'b0;
		test_reset();
		test_lorom_reads();
		test_hirom_reads();
		test_save_ram();
		test_open_bus();
		test_back_to_back();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* test/cart_map_properties.sv */
// concurrent assertions on the memory port strobes, bound to cart_mem_port

module cart_map_properties (
	input logic mclk,
	input logic rst,
	input logic rom_ce_n,
	input logic rom_oe_n,
	input logic bsram_ce_n,
	input logic bsram_oe_n,
	input logic bsram_we_n
);

	// save ram write only with the chip selected
	a_we_with_ce: assert property (
		@(posedge mclk) disable iff (rst) !bsram_we_n |-> !bsram_ce_n
	) else $error("bsram_we_n low while bsram_ce_n is high");

	// one memory drives the read data at a time
	a_oe_exclusive: assert property (
		@(posedge mclk) disable iff (rst) !(!rom_oe_n && !bsram_oe_n)
	) else $error("rom_oe_n and bsram_oe_n low together");

	// strobes come out of reset inactive
	a_idle_in_reset: assert property (
		@(posedge mclk) rst |=> (rom_ce_n && rom_oe_n && bsram_ce_n && bsram_oe_n && bsram_we_n)
	) else $error("port strobe active while in reset");

endmodule

bind cart_mem_port cart_map_properties u_props (
	.mclk       (mclk),
	.rst        (rst),
	.rom_ce_n   (rom_ce_n),
	.rom_oe_n   (rom_oe_n),
	.bsram_ce_n (bsram_ce_n),
	.bsram_oe_n (bsram_oe_n),
	.bsram_we_n (bsram_we_n)
);

/* rtl/cart_map_top.sv */
// cartridge map top level: bus capture, map decode and memory port instances
`include "cart_map_config.svh"

module cart_map_top (
	input  logic                      mclk,
	input  logic                      rst,
	input  logic                      sysclkf_ce,
	input  logic [`CART_ADDR_W-1:0]   cpu_addr,
	input  logic                      cpu_rd_n,
	input  logic                      cpu_wr_n,
	input  logic                      romsel_n,
	input  logic                      ramsel_n,
	input  logic [`CART_DATA_W-1:0]   cpu_di,
	input  cart_map_pkg::map_cfg_t    map_cfg,
	output logic [`CART_ADDR_W-1:0]   rom_addr,
	input  logic [`CART_ROM_Q_W-1:0]  rom_q,
	output logic                      rom_ce_n,
	output logic                      rom_oe_n,
	output logic [`CART_BSRAM_W-1:0]  bsram_addr,
	output logic [`CART_DATA_W-1:0]   bsram_d,
	input  logic [`CART_DATA_W-1:0]   bsram_q,
	output logic                      bsram_ce_n,
	output logic                      bsram_oe_n,
	output logic                      bsram_we_n,
	output logic [`CART_DATA_W-1:0]   cpu_do
);

	cart_map_pkg::bus_req_t bus_req;
	cart_map_pkg::mem_req_t mem_req;

	cpu_bus_capture u_capture (
		.mclk       (mclk),
		.rst        (rst),
		.sysclkf_ce (sysclkf_ce),
		.cpu_addr   (cpu_addr),
		.cpu_rd_n   (cpu_rd_n),
		.cpu_wr_n   (cpu_wr_n),
		.romsel_n   (romsel_n),
		.ramsel_n   (ramsel_n),
		.cpu_di     (cpu_di),
		.req        (bus_req)
	);

	map_decode u_decode (
		.mclk (mclk),
		.rst  (rst),
		.cfg  (map_cfg),
		.req  (bus_req),
		.mreq (mem_req)
	);

	cart_mem_port u_port (
		.mclk       (mclk),
		.rst        (rst),
		.mreq       (mem_req),
		.rom_addr   (rom_addr),
		.rom_q      (rom_q),
		.rom_ce_n   (rom_ce_n),
		.rom_oe_n   (rom_oe_n),
		.bsram_addr (bsram_addr),
		.bsram_d    (bsram_d),
		.bsram_q    (bsram_q),
		.bsram_ce_n (bsram_ce_n),
		.bsram_oe_n (bsram_oe_n),
		.bsram_we_n (bsram_we_n),
		.cpu_do     (cpu_do)
	);

endmodule

/* rtl/cart_mem_port.sv */
// memory port: registered rom and save ram drive, byte select and read return to the cpu
`include "cart_map_config.svh"

module cart_mem_port (
	input  logic                      mclk,
	input  logic                      rst,
	input  cart_map_pkg::mem_req_t    mreq,
	output logic [`CART_ADDR_W-1:0]   rom_addr,
	input  logic [`CART_ROM_Q_W-1:0]  rom_q,
	output logic                      rom_ce_n,
	output logic                      rom_oe_n,
	output logic [`CART_BSRAM_W-1:0]  bsram_addr,
	output logic [`CART_DATA_W-1:0]   bsram_d,
	input  logic [`CART_DATA_W-1:0]   bsram_q,
	output logic                      bsram_ce_n,
	output logic                      bsram_oe_n,
	output logic                      bsram_we_n,
	output logic [`CART_DATA_W-1:0]   cpu_do
);

	logic                    rom_acc;
	logic                    bsram_acc;
	logic [`CART_DATA_W-1:0] rom_byte;

	assign rom_acc   = mreq.valid && (mreq.target == cart_map_pkg::TGT_ROM);
	assign bsram_acc = mreq.valid && (mreq.target == cart_map_pkg::TGT_BSRAM);

	// strobes last one clock per request
	always_ff @(posedge mclk) begin
		if (rst) begin
			rom_ce_n   <= 1'b1;
			rom_oe_n   <= 1'b1;
			bsram_ce_n <= 1'b1;
			bsram_oe_n <= 1'b1;
			bsram_we_n <= 1'b1;
		end else begin
			rom_ce_n   <= ~rom_acc;
			rom_oe_n   <= ~(rom_acc & mreq.rd);
			bsram_ce_n <= ~bsram_acc;
			bsram_oe_n <= ~(bsram_acc & mreq.rd);
			bsram_we_n <= ~(bsram_acc & mreq.wr);
		end
	end

	// addresses and write data follow each request
	always_ff @(posedge mclk) begin
		if (mreq.valid) begin
			rom_addr   <= mreq.rom_addr;
			bsram_addr <= mreq.bsram_addr;
			bsram_d    <= mreq.wdata;
		end
	end

	// odd address takes the upper byte of the rom word
	assign rom_byte = rom_addr[0] ? rom_q[15:8] : rom_q[7:0];

	// memories answer combinationally while the strobes are low;
	// no hit keeps the last byte (open bus)
	always_ff @(posedge mclk) begin
		if (rst) begin
			cpu_do <= '0;
		end else if (!rom_oe_n) begin
			cpu_do <= rom_byte;
		end else if (!bsram_oe_n) begin
			cpu_do <= bsram_q;
		end
	end

endmodule

/* map_decode/map_decode.sv */
// map decode with lorom and hirom address decode and rom and save ram masks
`include "cart_map_config.svh"

module map_decode (
	input  logic                   mclk,
	input  logic                   rst,
	input  cart_map_pkg::map_cfg_t cfg,
	input  cart_map_pkg::bus_req_t req,
	output cart_map_pkg::mem_req_t mreq
);

	cart_map_pkg::cpu_addr_u   addr;
	logic                      has_bsram;

	logic                      lo_bsram_hit;
	logic [`CART_BSRAM_W-1:0]  lo_bsram_addr;
	logic [`CART_ADDR_W-1:0]   lo_rom_addr;

	logic                      hi_bsram_hit;
	logic [`CART_BSRAM_W-1:0]  hi_bsram_addr;
	logic [`CART_ADDR_W-1:0]   hi_rom_addr;

	logic                      bsram_hit;
	cart_map_pkg::mem_target_e target;
	logic [`CART_ADDR_W-1:0]   rom_addr;
	logic [`CART_BSRAM_W-1:0]  bsram_addr;

	cart_map_pkg::mem_req_t    data_q;

	assign addr = req.addr;

	// zero mask means no save ram fitted
	assign has_bsram = |cfg.bsram_mask;

	// lorom banks 70-7d carry the save ram in their lower 32K
	assign lo_bsram_hit = req.romsel
		&& (addr.lorom.bank >= `CART_LO_SRAM_FIRST)
		&& (addr.lorom.bank <= `CART_LO_SRAM_LAST)
		&& !addr.lorom.a15
		&& has_bsram;

	assign lo_bsram_addr = {1'b0, addr.lorom.bank[3:0], addr.lorom.offset} & cfg.bsram_mask;

	// 32K windows stacked by bank with a15 dropped
	assign lo_rom_addr = {2'b00, addr.lorom.bank[6:0], addr.lorom.offset} & cfg.rom_mask;

	// hirom save ram at 6000-7fff of banks 20-3f and a0-bf
	assign hi_bsram_hit = !req.romsel
		&& !addr.hirom.bank[6]
		&& addr.hirom.bank[5]
		&& (addr.hirom.offset[15:13] == `CART_HI_SRAM_PAGE)
		&& has_bsram;

	// 8K per bank
	assign hi_bsram_addr = {2'b00, addr.hirom.bank[4:0], addr.hirom.offset[12:0]}
		& cfg.bsram_mask;

	assign hi_rom_addr = {2'b00, addr.hirom.bank[5:0], addr.hirom.offset} & cfg.rom_mask;

	always_comb begin
		if (cfg.mode == cart_map_pkg::MAP_HIROM) begin
			bsram_hit  = hi_bsram_hit;
			rom_addr   = hi_rom_addr;
			bsram_addr = hi_bsram_addr;
		end else begin
			bsram_hit  = lo_bsram_hit;
			rom_addr   = lo_rom_addr;
			bsram_addr = lo_bsram_addr;
		end
	end

	// rom is read only so a rom write goes nowhere
	always_comb begin
		if (bsram_hit) begin
			target = cart_map_pkg::TGT_BSRAM;
		end else if (req.romsel && !req.wr) begin
			target = cart_map_pkg::TGT_ROM;
		end else begin
			target = cart_map_pkg::TGT_NONE;
		end
	end

	always_ff @(posedge mclk) begin
		if (rst) begin
			data_q.valid <= 1'b0;
		end else begin
			data_q.valid <= req.valid;
		end
		data_q.target     <= target;
		data_q.rd         <= req.rd;
		data_q.wr         <= req.wr;
		data_q.rom_addr   <= rom_addr;
		data_q.bsram_addr <= bsram_addr;
		data_q.wdata      <= req.wdata;
	end

	assign mreq = data_q;

endmodule

/* rtl/cpu_bus_capture.sv */
// cpu bus capture that samples a qualified bus cycle into a bus request
`include "cart_map_config.svh"

module cpu_bus_capture (
	input  logic                     mclk,
	input  logic                     rst,
	input  logic                     sysclkf_ce,
	input  logic [`CART_ADDR_W-1:0]  cpu_addr,
	input  logic                     cpu_rd_n,
	input  logic                     cpu_wr_n,
	input  logic                     romsel_n,
	input  logic                     ramsel_n,
	input  logic [`CART_DATA_W-1:0]  cpu_di,
	output cart_map_pkg::bus_req_t   req
);

	logic                   bus_cycle;
	cart_map_pkg::bus_req_t data_q;

	// a bus cycle starts on the falling system clock with a strobe down
	assign bus_cycle = sysclkf_ce & (~cpu_rd_n | ~cpu_wr_n);

	// valid lasts one mclk per captured cycle
	always_ff @(posedge mclk) begin
		if (rst) begin
			data_q.valid <= 1'b0;
		end else begin
			data_q.valid <= bus_cycle;
		end
		if (bus_cycle) begin
			data_q.addr   <= cpu_addr;
			data_q.rd     <= ~cpu_rd_n;
			// both strobes low is treated as a read
			data_q.wr     <= ~cpu_wr_n & cpu_rd_n;
			data_q.romsel <= ~romsel_n;
			data_q.ramsel <= ~ramsel_n;
			data_q.wdata  <= cpu_di;
		end
	end

	assign req = data_q;

endmodule

/* common/cart_map_pkg.sv */
// cartridge map types: bus address union, map config, bus and memory request structs
`include "cart_map_config.svh"

package cart_map_pkg;

	// lorom splits the bank into 32 KiB halves
	typedef struct packed {
		logic [7:0]  bank;
		logic        a15;
		logic [14:0] offset;
	} lorom_view_t;

	// hirom uses the whole 64 KiB bank
	typedef struct packed {
		logic [7:0]  bank;
		logic [15:0] offset;
	} hirom_view_t;

	// one bus address, read either way depending on the map mode
	typedef union packed {
		lorom_view_t lorom;
		hirom_view_t hirom;
	} cpu_addr_u;

	typedef enum logic {
		MAP_LOROM,
		MAP_HIROM
	} map_mode_e;

	// static cartridge setup, held after reset
	typedef struct packed {
		map_mode_e                mode;
		logic [`CART_ADDR_W-1:0]  rom_mask;
		logic [`CART_BSRAM_W-1:0] bsram_mask;
	} map_cfg_t;

	// one captured bus cycle, strobes active high
	typedef struct packed {
		logic                    valid;
		cpu_addr_u               addr;
		logic                    rd;
		logic                    wr;
		logic                    romsel;
		logic                    ramsel;
		logic [`CART_DATA_W-1:0] wdata;
	} bus_req_t;

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_ROM,
		TGT_BSRAM
	} mem_target_e;

	// decoded access with masked physical addresses
	typedef struct packed {
		logic                     valid;
		mem_target_e              target;
		logic                     rd;
		logic                     wr;
		logic [`CART_ADDR_W-1:0]  rom_addr;
		logic [`CART_BSRAM_W-1:0] bsram_addr;
		logic [`CART_DATA_W-1:0]  wdata;
	} mem_req_t;

endpackage

/* common/cart_map_config.svh */
// bus widths, save ram bank ranges and hirom save ram window for the cartridge map
`ifndef CART_MAP_CONFIG_SVH
`define CART_MAP_CONFIG_SVH

// cpu bus address, also the rom address width
`define CART_ADDR_W 24

// save ram address width
`define CART_BSRAM_W 20

// cpu data bus
`define CART_DATA_W 8

// rom read word, two bytes
`define CART_ROM_Q_W 16

// lorom save ram banks 70-7d, lower half only
`define CART_LO_SRAM_FIRST 8'h70
`define CART_LO_SRAM_LAST 8'h7D

// hirom save ram sits at 6000-7fff, address bits 15:13
`define CART_HI_SRAM_PAGE 3'b011

`endif
